/* flist.f */
+incdir+verilog
verilog/playground_pkg.sv
verilog/io_bus_decode.sv
verilog/io_regs.sv
verilog/reload_timer.sv
verilog/sigma_delta_dac.sv
verilog/playground_io.sv
tests/tb_playground_io.sv

/* run_sim.sh */
#!/bin/sh
# Build the playground IO testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_playground_io \
   -o tb_playground_io > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_playground_io > sim.log 2>&1

grep -q "^PASS: all tests$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

/* tests/playground_stim.hex */
// Columns: kind (0 write, 1 read and compare, 2 set port_in, 3 end), address, data, expected
// Write expected is the stored register value, read expected is rdata
00000001 40000010 00000000 00000000
00000001 40000020 00000000 00000000
00000001 40000040 00000000 00000000
00000001 40000100 00000000 00000000
00000001 40000200 00000000 00000000
00000001 40000400 00000000 00000000
00000001 40000800 00000000 00000000
00000001 40080000 00000000 00000000
00000000 40000020 000000a5 000000a5
00000001 40000020 00000000 000000a5
00000000 40000040 0000003c 0000003c
00000001 40000040 00000000 0000003c
00000002 00000000 0000015a 00000000
00000001 40000010 00000000 0000015a
00000000 40000100 00000005 00000005
00000001 40000100 00000000 00000055
00000001 80000020 00000000 00000055
00000000 80000020 ffffffff 00000000
00000001 40000020 00000000 000000a5
00000001 40000080 00000000 00000000
00000001 40001000 00000000 00000000
00000001 40000060 00000000 000000bd
00000000 40000024 00000021 00000084
00000000 40000028 00000013 00000097
00000000 4000002c 000000ff 00000068
00000001 40000020 00000000 00000068
00000000 40000108 0000000a 0000000f
00000000 40000104 00000003 0000000c
00000001 40000100 00000000 0000004c
00000000 40000044 000000f0 0000000c
00000001 40000040 00000000 0000000c
00000000 40000020 12345678 00000078
00000001 40000020 00000000 00000078
00000000 40000200 00001234 00001234
00000000 4000040c 0000ffff 0000ffff
00000000 40000808 0000a5a5 0000a5a5
00000000 40000204 00000030 00001204
00000001 40000200 00000000 00001204
00000001 40000400 00000000 0000ffff
00000001 40000800 00000000 0000a5a5
00000000 40080000 deadbeef deadbeef
00000001 40080000 00000000 deadbeef
00000003 00000000 00000000 00000000

/* tests/tb_playground_io.sv */
// Testbench for the playground IO block
// Replays bus records from the stim file against a register model,
// then random GPIO traffic, reload timer and sigma-delta checks

`timescale 1ns/1ps

`include "playground_consts.svh"

module tb_playground_io;

   // Select index is the address bit minus the select base
   localparam int IDX_IN     = `PG_SEL_PORT_IN   - `PG_SEL_LSB;
   localparam int IDX_OUT    = `PG_SEL_PORT_OUT  - `PG_SEL_LSB;
   localparam int IDX_DIR    = `PG_SEL_PORT_DIR  - `PG_SEL_LSB;
   localparam int IDX_LEDS   = `PG_SEL_LEDS      - `PG_SEL_LSB;
   localparam int IDX_RED    = `PG_SEL_SDM_RED   - `PG_SEL_LSB;
   localparam int IDX_GREEN  = `PG_SEL_SDM_GREEN - `PG_SEL_LSB;
   localparam int IDX_BLUE   = `PG_SEL_SDM_BLUE  - `PG_SEL_LSB;
   localparam int IDX_TICKS  = `PG_SEL_TICKS     - `PG_SEL_LSB;
   localparam int IDX_RELOAD = `PG_SEL_RELOAD    - `PG_SEL_LSB;
   localparam int STIM_WORDS = 256;   // Up to 64 records of four words
   localparam int WAIT_LIMIT = 100;   // Cycle limit of each wait loop

   localparam logic [31:0] IO_BASE       = {`PG_REGION_IO, 28'h0};
   localparam logic [31:0] ADDR_PORT_IN  = IO_BASE | (32'h1 << `PG_SEL_PORT_IN);
   localparam logic [31:0] ADDR_PORT_OUT = IO_BASE | (32'h1 << `PG_SEL_PORT_OUT);
   localparam logic [31:0] ADDR_LEDS     = IO_BASE | (32'h1 << `PG_SEL_LEDS);
   localparam logic [31:0] ADDR_RED      = IO_BASE | (32'h1 << `PG_SEL_SDM_RED);
   localparam logic [31:0] ADDR_GREEN    = IO_BASE | (32'h1 << `PG_SEL_SDM_GREEN);
   localparam logic [31:0] ADDR_BLUE     = IO_BASE | (32'h1 << `PG_SEL_SDM_BLUE);
   localparam logic [31:0] ADDR_TICKS    = IO_BASE | (32'h1 << `PG_SEL_TICKS);
   localparam logic [31:0] ADDR_RELOAD   = IO_BASE | (32'h1 << `PG_SEL_RELOAD);

   logic                      clk;
   logic                      reset_button;
   playground_pkg::bus_req_t  bus_req;
   logic [`PG_PORT_IN_W-1:0]  port_in;
   logic [31:0]               rdata;
   playground_pkg::gpio_out_t gpio;
   logic [2:0]                led_drive;   // [0] red
   logic                      interrupt;

   logic [31:0] stim [0:STIM_WORDS-1];
   logic [31:0] model [0:15];   // Expected register contents by select index
   logic [31:0] last_rdata;     // Last value seen on rdata

   playground_io u_playground_io (
      .clk          (clk),
      .reset_button (reset_button),
      .bus_req      (bus_req),
      .port_in      (port_in),
      .rdata        (rdata),
      .gpio         (gpio),
      .led_drive    (led_drive),
      .interrupt    (interrupt)
   );

   always #4 clk = ~clk;   // 8 ns period

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                             $time, name, actual, expected));
      end
   endtask

   // Stored bits per register or zero where the model keeps none
   function automatic logic [31:0] reg_mask(input int idx);
      case (idx)
         IDX_OUT, IDX_DIR:             return (32'h1 << `PG_GPIO_W) - 1;
         IDX_LEDS:                     return (32'h1 << `PG_LED_W) - 1;
         IDX_RED, IDX_GREEN, IDX_BLUE: return (32'h1 << `PG_SDM_W) - 1;
         IDX_RELOAD:                   return 32'hffff_ffff;
         default:                      return 32'h0;
      endcase
   endfunction

   // Predicted read value unless drive bits or ticks take part
   function automatic logic [31:0] model_value(input logic [31:0] addr, output bit known);
      logic [31:0] value;
      int          i;
      value = '0;
      known = 1'b1;
      if (addr[`PG_REGION_MSB:`PG_REGION_LSB] != `PG_REGION_IO) return last_rdata;
      for (i = 0; i < 16; i++) begin
         if (addr[i + `PG_SEL_LSB]) begin
            if (i == IDX_LEDS || i == IDX_TICKS) known = 1'b0;
            value |= model[i];   // Several selects OR together
         end
      end
      return value;
   endfunction

   task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] stored);
      logic [31:0] old_value;
      logic [31:0] new_value;
      bit          known;
      int          i;
      stored = '0;
      if (addr[`PG_REGION_MSB:`PG_REGION_LSB] != `PG_REGION_IO) return;
      old_value = model_value(addr, known);
      case (addr[`PG_OP_LSB+1:`PG_OP_LSB])
         `PG_OP_CLEAR:  new_value = old_value & ~data;
         `PG_OP_SET:    new_value = old_value | data;
         `PG_OP_TOGGLE: new_value = old_value ^ data;
         default:       new_value = data;
      endcase
      for (i = 0; i < 16; i++) begin
         if (addr[i + `PG_SEL_LSB] && reg_mask(i) != 0) begin
            model[i] = (i == IDX_RELOAD) ? data : (new_value & reg_mask(i));   // Reload takes raw
            stored   = model[i];
         end
      end
   endtask

   // One strobe cycle followed by an idle cycle
   task automatic drive_bus(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wmask, input logic rstrb);
      playground_pkg::bus_req_t req;
      req.addr  = addr;
      req.wdata = wdata;
      req.wmask = wmask;
      req.rstrb = rstrb;
      @(posedge clk);
      bus_req <= req;
      @(posedge clk);     // DUT takes the strobe here
      bus_req <= '0;
   endtask

   task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic [31:0] stored);
      model_write(addr, data, stored);
      drive_bus(addr, data, 4'hf, 1'b0);
      @(negedge clk);
      check_value("gpio", {16'h0, gpio},
                  {16'h0, model[IDX_OUT][`PG_GPIO_W-1:0], model[IDX_DIR][`PG_GPIO_W-1:0]});
   endtask

   task automatic do_read(input logic [31:0] addr, output logic [31:0] value);
      logic [31:0] predicted;
      bit          known;
      predicted = model_value(addr, known);
      drive_bus(addr, 32'h0, 4'h0, 1'b1);
      @(negedge clk);     // One cycle of read latency
      value = rdata;
      if (known) check_value("rdata against model", value, predicted);
      last_rdata = value;
   endtask

   task automatic set_port_in(input logic [31:0] pins);
      @(posedge clk);
      port_in <= pins[`PG_PORT_IN_W-1:0];
      model[IDX_IN] = pins & ((32'h1 << `PG_PORT_IN_W) - 1);
   endtask

   task automatic run_stim_file();
      logic [31:0] kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] expected;
      logic [31:0] value;
      int          rec;
      $readmemh("tests/playground_stim.hex", stim);
      for (rec = 0; rec < STIM_WORDS / 4; rec++) begin
         kind     = stim[4*rec];
         addr     = stim[4*rec + 1];
         data     = stim[4*rec + 2];
         expected = stim[4*rec + 3];
         case (kind)
            32'd0: begin
               do_write(addr, data, value);
               check_value("stored value", value, expected);   // Model against file
            end
            32'd1: begin
               do_read(addr, value);
               check_value("rdata", value, expected);
            end
            32'd2:   set_port_in(data);
            32'd3:   return;                                   // End record
            default: abort_run($sformatf("Stim record %0d has unknown kind %h", rec, kind));
         endcase
      end
      abort_run("The stim file ends without an end record");
   endtask

   // Random pin patterns and random modifier writes to port_out
   task automatic random_gpio();
      logic [31:0] addr;
      logic [31:0] value;
      int          n;
      for (n = 0; n < 8; n++) begin
         set_port_in($urandom);
         do_read(ADDR_PORT_IN, value);
         addr = ADDR_PORT_OUT | (($urandom % 4) << `PG_OP_LSB);
         do_write(addr, $urandom, value);
         do_read(ADDR_PORT_OUT, value);
      end
   endtask

   task automatic timer_check();
      logic [31:0] start;
      logic [31:0] reload_value;
      logic [31:0] value;
      int          edges;
      start        = 32'hffff_ffec;   // 20 counts before the wrap
      reload_value = 32'h0000_0100;
      do_write(ADDR_RELOAD, reload_value, value);
      do_write(ADDR_TICKS, start, value);
      edges = 0;                      // Edges since the write edge
      while (interrupt !== 1'b1 && edges < WAIT_LIMIT) begin
         @(negedge clk);
         edges++;
      end
      if (interrupt !== 1'b1) begin
         abort_run("Timeout waiting for the timer interrupt");
      end else begin
         check_value("interrupt delay", edges, ~start + 32'd1);
         @(negedge clk);
         check_value("interrupt after pulse", {31'h0, interrupt}, 32'h0);
         // Pulse cycle holds reload and the read strobe samples two cycles later
         do_read(ADDR_TICKS, value);
         check_value("ticks after reload", value, reload_value + 32'd2);
      end
   endtask

   task automatic sdm_check();
      logic [31:0] value;
      logic [31:0] red_level;
      logic [31:0] green_level;
      logic [31:0] blue_level;
      logic [3:0]  override;
      int          red_count;
      int          green_count;
      int          blue_count;
      int          k;
      int          n;
      red_level   = 32'h1234;
      green_level = 32'h0f0f;
      blue_level  = 32'hc001;
      do_write(ADDR_LEDS, 32'h0, value);
      do_write(ADDR_GREEN, green_level, value);
      do_write(ADDR_BLUE, blue_level, value);
      do_write(ADDR_RED, red_level, value);
      red_count   = 0;
      green_count = 0;
      blue_count  = 0;
      for (n = 0; n < 65536; n++) begin   // One full accumulator period
         @(negedge clk);
         red_count   += led_drive[0];
         green_count += led_drive[1];
         blue_count  += led_drive[2];
      end
      check_value("red pulse count", red_count, red_level);
      check_value("green pulse count", green_count, green_level);
      check_value("blue pulse count", blue_count, blue_level);
      do_write(ADDR_RED, 32'h0, value);
      do_write(ADDR_GREEN, 32'h0, value);
      do_write(ADDR_BLUE, 32'h0, value);
      for (n = 0; n < 256; n++) begin
         @(negedge clk);                  // Zero levels add no carry from here
         check_value("led_drive at level 0", {29'h0, led_drive}, 32'h0);
      end
      for (k = 0; k < 2; k++) begin
         override = (k == 0) ? 4'hd : 4'h2;   // Red, blue and spare bit, then green alone
         do_write(ADDR_LEDS, {28'h0, override}, value);
         for (n = 0; n < 64; n++) begin
            check_value("led_drive with overrides", {29'h0, led_drive},
                        {29'h0, override[2:0]});
            @(negedge clk);
         end
         do_read(ADDR_LEDS, value);
         check_value("leds read", value, {25'h0, override[2:0], override});
      end
   endtask

   initial begin
      int i;
      void'($urandom(32'h34a3));
      clk          = 1'b0;
      reset_button = 1'b1;
      bus_req      = '0;
      port_in      = '0;
      last_rdata   = '0;
      for (i = 0; i < 16; i++) model[i] = '0;
      repeat (3) @(posedge clk);
      reset_button <= 1'b0;
      @(negedge clk);
      check_value("gpio after reset", {16'h0, gpio}, 32'h0);
      check_value("led_drive after reset", {29'h0, led_drive}, 32'h0);
      check_value("interrupt after reset", {31'h0, interrupt}, 32'h0);
      check_value("rdata after reset", rdata, 32'h0);
      run_stim_file();
      random_gpio();
      timer_check();
      sdm_check();
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* verilog/io_bus_decode.sv */
// IO region decoder
// Gates read and write strobes with the region compare and
// splits the address into one-hot selects and modifier code

`timescale 1ns/1ps

`include "playground_consts.svh"

module io_bus_decode (
   input  playground_pkg::bus_req_t   bus_req,
   output playground_pkg::io_access_t io_acc
);

   logic is_io;     // Address falls in the IO region
   logic wr_strb;   // Any byte lane written

   // Only the top nibble decides the region
   assign is_io = (bus_req.addr[`PG_REGION_MSB:`PG_REGION_LSB] == `PG_REGION_IO);

   // IO writes are word-only, so any lane counts as a full write
   assign wr_strb = |bus_req.wmask;

   always_comb begin
      io_acc.rd    = bus_req.rstrb & is_io;
      io_acc.wr    = wr_strb & is_io;
      io_acc.sel   = bus_req.addr[`PG_SEL_MSB:`PG_SEL_LSB];   // One-hot register select
      io_acc.op    = bus_req.addr[`PG_OP_LSB+1:`PG_OP_LSB];   // Modifier offset
      io_acc.wdata = bus_req.wdata;
   end

endmodule

/* verilog/io_regs.sv */
// IO register block
// GPIO out and dir, LED overrides and brightness registers,
// OR-combined read mux, clear/set/toggle modifier and
// buffered read data

`timescale 1ns/1ps

`include "playground_consts.svh"

module io_regs (
   input  logic                       clk,
   input  logic                       reset_button,
   input  playground_pkg::io_access_t io_acc,
   input  logic [`PG_PORT_IN_W-1:0]   port_in,     // Pins plus spare bit
   input  logic [2:0]                 led_out,     // Modulator outputs, [0] red
   input  logic [`PG_XLEN-1:0]        ticks,
   input  logic [`PG_XLEN-1:0]        reload,
   output playground_pkg::gpio_out_t  gpio,
   output logic [`PG_LED_W-1:0]       leds,
   output playground_pkg::led_level_t levels,
   output logic [`PG_XLEN-1:0]        rdata
);

   // Select indices inside io_acc.sel
   localparam int SEL_IN     = `PG_SEL_PORT_IN   - `PG_SEL_LSB;
   localparam int SEL_OUT    = `PG_SEL_PORT_OUT  - `PG_SEL_LSB;
   localparam int SEL_DIR    = `PG_SEL_PORT_DIR  - `PG_SEL_LSB;
   localparam int SEL_LEDS   = `PG_SEL_LEDS      - `PG_SEL_LSB;
   localparam int SEL_RED    = `PG_SEL_SDM_RED   - `PG_SEL_LSB;
   localparam int SEL_GREEN  = `PG_SEL_SDM_GREEN - `PG_SEL_LSB;
   localparam int SEL_BLUE   = `PG_SEL_SDM_BLUE  - `PG_SEL_LSB;
   localparam int SEL_TICKS  = `PG_SEL_TICKS     - `PG_SEL_LSB;
   localparam int SEL_RELOAD = `PG_SEL_RELOAD    - `PG_SEL_LSB;

   // Zero fill for narrow registers
   localparam int PAD_IN   = `PG_XLEN - `PG_PORT_IN_W;
   localparam int PAD_GPIO = `PG_XLEN - `PG_GPIO_W;
   localparam int PAD_LEDS = `PG_XLEN - `PG_LED_W - 3;
   localparam int PAD_SDM  = `PG_XLEN - `PG_SDM_W;

   logic [`PG_GPIO_W-1:0] port_out;
   logic [`PG_GPIO_W-1:0] port_dir;
   logic [`PG_SDM_W-1:0]  sdm_red;
   logic [`PG_SDM_W-1:0]  sdm_green;
   logic [`PG_SDM_W-1:0]  sdm_blue;

   logic [`PG_XLEN-1:0]   rd_mux;        // Combined value of all selected registers
   logic [`PG_XLEN-1:0]   io_modifier;   // Value to store on a write

   // Read mux, several selects OR together
   always_comb begin
      rd_mux = '0;
      if (io_acc.sel[SEL_IN])     rd_mux |= {{PAD_IN{1'b0}}, port_in};
      if (io_acc.sel[SEL_OUT])    rd_mux |= {{PAD_GPIO{1'b0}}, port_out};
      if (io_acc.sel[SEL_DIR])    rd_mux |= {{PAD_GPIO{1'b0}}, port_dir};
      // Drive state above the overrides, blue highest
      if (io_acc.sel[SEL_LEDS])   rd_mux |= {{PAD_LEDS{1'b0}}, led_out, leds};
      if (io_acc.sel[SEL_RED])    rd_mux |= {{PAD_SDM{1'b0}}, sdm_red};
      if (io_acc.sel[SEL_GREEN])  rd_mux |= {{PAD_SDM{1'b0}}, sdm_green};
      if (io_acc.sel[SEL_BLUE])   rd_mux |= {{PAD_SDM{1'b0}}, sdm_blue};
      if (io_acc.sel[SEL_TICKS])  rd_mux |= ticks;
      if (io_acc.sel[SEL_RELOAD]) rd_mux |= reload;
   end

   // Old value comes from the read mux
   always_comb begin
      case (io_acc.op)
         `PG_OP_CLEAR:  io_modifier = rd_mux & ~io_acc.wdata;
         `PG_OP_SET:    io_modifier = rd_mux |  io_acc.wdata;
         `PG_OP_TOGGLE: io_modifier = rd_mux ^  io_acc.wdata;
         default:       io_modifier = io_acc.wdata;            // Plain write
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_button) begin
         port_out  <= '0;
         port_dir  <= '0;   // All pins inputs
         leds      <= '0;
         sdm_red   <= '0;
         sdm_green <= '0;
         sdm_blue  <= '0;
      end else if (io_acc.wr) begin
         if (io_acc.sel[SEL_OUT])   port_out  <= io_modifier[`PG_GPIO_W-1:0];
         if (io_acc.sel[SEL_DIR])   port_dir  <= io_modifier[`PG_GPIO_W-1:0];
         if (io_acc.sel[SEL_LEDS])  leds      <= io_modifier[`PG_LED_W-1:0];
         if (io_acc.sel[SEL_RED])   sdm_red   <= io_modifier[`PG_SDM_W-1:0];
         if (io_acc.sel[SEL_GREEN]) sdm_green <= io_modifier[`PG_SDM_W-1:0];
         if (io_acc.sel[SEL_BLUE])  sdm_blue  <= io_modifier[`PG_SDM_W-1:0];
      end
   end

   // Read data is captured in the strobe cycle and held until the next IO read
   always_ff @(posedge clk) begin
      if (reset_button) begin
         rdata <= '0;
      end else if (io_acc.rd) begin
         rdata <= rd_mux;
      end
   end

   assign gpio.port_out = port_out;
   assign gpio.port_dir = port_dir;

   assign levels.red   = sdm_red;
   assign levels.green = sdm_green;
   assign levels.blue  = sdm_blue;

endmodule

/* verilog/playground_consts.svh */
// Shared constants for the playground IO block
// Bus width, region decode, one-hot IO select bits,
// write modifier codes and GPIO, LED and modulator widths

`ifndef PLAYGROUND_CONSTS_SVH
`define PLAYGROUND_CONSTS_SVH

`define PG_XLEN          32     // Bus data and address width

// Region field, top nibble of the address
`define PG_REGION_MSB    31
`define PG_REGION_LSB    28
`define PG_REGION_IO     4'h4   // 0x4000_0000

// One-hot register selects, address bits 19..4
`define PG_SEL_LSB       4
`define PG_SEL_MSB       19
`define PG_SEL_PORT_IN   4      // RO, [8] spare input
`define PG_SEL_PORT_OUT  5
`define PG_SEL_PORT_DIR  6
`define PG_SEL_LEDS      8      // [6:4] drive state, [3:0] overrides
`define PG_SEL_SDM_RED   9
`define PG_SEL_SDM_GREEN 10
`define PG_SEL_SDM_BLUE  11
`define PG_SEL_TICKS     18
`define PG_SEL_RELOAD    19

// Modifier field in address bits 3:2
`define PG_OP_LSB        2
`define PG_OP_WRITE      2'd0   // +0x0
`define PG_OP_CLEAR      2'd1   // +0x4
`define PG_OP_SET        2'd2   // +0x8
`define PG_OP_TOGGLE     2'd3   // +0xC

`define PG_GPIO_W        8
`define PG_PORT_IN_W     9      // Pins plus spare bit
`define PG_LED_W         4
`define PG_SDM_W         16     // Brightness resolution

`endif

/* verilog/playground_io.sv */
// Top level of the playground IO block
// Bus decoder, register block, reload timer and
// three LED modulator channels

`timescale 1ns/1ps

`include "playground_consts.svh"

module playground_io (
   input  logic                      clk,
   input  logic                      reset_button,
   input  playground_pkg::bus_req_t  bus_req,
   input  logic [`PG_PORT_IN_W-1:0]  port_in,     // [8] spare input bit
   output logic [`PG_XLEN-1:0]       rdata,       // Valid from the edge after the read
   output playground_pkg::gpio_out_t gpio,
   output logic [2:0]                led_drive,   // [0] red, [1] green, [2] blue
   output logic                      interrupt
);

   playground_pkg::io_access_t io_acc;
   playground_pkg::led_level_t levels;

   logic [`PG_LED_W-1:0] leds;     // Override bits, [3] spare
   logic [`PG_XLEN-1:0]  ticks;
   logic [`PG_XLEN-1:0]  reload;

   io_bus_decode u_io_bus_decode (
      .bus_req (bus_req),
      .io_acc  (io_acc)
   );

   io_regs u_io_regs (
      .clk          (clk),
      .reset_button (reset_button),
      .io_acc       (io_acc),
      .port_in      (port_in),
      .led_out      (led_drive),   // Read back in the LEDs register
      .ticks        (ticks),
      .reload       (reload),
      .gpio         (gpio),
      .leds         (leds),
      .levels       (levels),
      .rdata        (rdata)
   );

   reload_timer u_reload_timer (
      .clk          (clk),
      .reset_button (reset_button),
      .io_acc       (io_acc),
      .ticks        (ticks),
      .reload       (reload),
      .interrupt    (interrupt)
   );

   // One channel per colour, override bit with matching index
   sigma_delta_dac #(.WIDTH(`PG_SDM_W)) u_sdm_red (
      .clk          (clk),
      .reset_button (reset_button),
      .level        (levels.red),
      .force_on     (leds[0]),
      .drive        (led_drive[0])
   );

   sigma_delta_dac #(.WIDTH(`PG_SDM_W)) u_sdm_green (
      .clk          (clk),
      .reset_button (reset_button),
      .level        (levels.green),
      .force_on     (leds[1]),
      .drive        (led_drive[1])
   );

   sigma_delta_dac #(.WIDTH(`PG_SDM_W)) u_sdm_blue (
      .clk          (clk),
      .reset_button (reset_button),
      .level        (levels.blue),
      .force_on     (leds[2]),
      .drive        (led_drive[2])
   );

endmodule

/* verilog/playground_pkg.sv */
// Bus and register types of the playground IO block
// Bus request, decoded IO access, LED levels and GPIO outputs

`include "playground_consts.svh"

package playground_pkg;

   // One cycle on the external bus
   typedef struct packed {
      logic [`PG_XLEN-1:0] addr;
      logic [`PG_XLEN-1:0] wdata;
      logic [3:0]          wmask;   // Any bit set means write
      logic                rstrb;   // Read strobe
   } bus_req_t;

   // IO access after region decode, valid for one cycle
   typedef struct packed {
      logic                                rd;
      logic                                wr;
      logic [`PG_SEL_MSB-`PG_SEL_LSB:0]    sel;    // Address bits 19..4, one-hot
      logic [1:0]                          op;     // Write, clear, set, toggle
      logic [`PG_XLEN-1:0]                 wdata;
   } io_access_t;

   // Brightness per colour channel
   typedef struct packed {
      logic [`PG_SDM_W-1:0] red;
      logic [`PG_SDM_W-1:0] green;
      logic [`PG_SDM_W-1:0] blue;
   } led_level_t;

   // GPIO pin drive
   typedef struct packed {
      logic [`PG_GPIO_W-1:0] port_out;
      logic [`PG_GPIO_W-1:0] port_dir;   // 1 drives the pin
   } gpio_out_t;

endpackage

/* verilog/reload_timer.sv */
// Reload timer
// Free-running tick counter, reload on overflow and
// one-cycle interrupt pulse

`timescale 1ns/1ps

`include "playground_consts.svh"

module reload_timer (
   input  logic                       clk,
   input  logic                       reset_button,
   input  playground_pkg::io_access_t io_acc,
   output logic [`PG_XLEN-1:0]        ticks,
   output logic [`PG_XLEN-1:0]        reload,
   output logic                       interrupt
);

   localparam int SEL_TICKS  = `PG_SEL_TICKS  - `PG_SEL_LSB;
   localparam int SEL_RELOAD = `PG_SEL_RELOAD - `PG_SEL_LSB;

   logic [`PG_XLEN:0]   ticks_plus_1;   // Carry out marks overflow
   logic [`PG_XLEN-1:0] next_ticks;

   assign ticks_plus_1 = {1'b0, ticks} + 1'b1;
   assign next_ticks   = ticks_plus_1[`PG_XLEN] ? reload : ticks_plus_1[`PG_XLEN-1:0];

   always_ff @(posedge clk) begin
      if (reset_button) begin
         ticks     <= '0;
         reload    <= '0;
         interrupt <= 1'b0;
      end else begin
         // Raw write data, the modifier does not apply here
         if (io_acc.wr && io_acc.sel[SEL_TICKS]) ticks <= io_acc.wdata;
         else                                    ticks <= next_ticks;

         if (io_acc.wr && io_acc.sel[SEL_RELOAD]) reload <= io_acc.wdata;   // Counting goes on

         interrupt <= ticks_plus_1[`PG_XLEN];   // High one cycle after the wrap
      end
   end

endmodule

/* verilog/sigma_delta_dac.sv */
// First-order sigma-delta modulator channel
// Phase accumulator with registered carry and override input

`timescale 1ns/1ps

`include "playground_consts.svh"

module sigma_delta_dac #(
   parameter int WIDTH = `PG_SDM_W
) (
   input  logic             clk,
   input  logic             reset_button,
   input  logic [WIDTH-1:0] level,      // Duty cycle is level / 2**WIDTH
   input  logic             force_on,   // Holds the output high
   output logic             drive
);

   logic [WIDTH-1:0] phase;
   logic             carry;

   // Carry rate over 2**WIDTH cycles equals level
   always_ff @(posedge clk) begin
      if (reset_button) begin
         phase <= '0;
         carry <= 1'b0;
      end else begin
         {carry, phase} <= {1'b0, phase} + {1'b0, level};
      end
   end

   assign drive = carry | force_on;

endmodule
